//--- list.f
hw/panel_pkg.sv
hw/opcode_dispatch.sv
hw/display_settings.sv
hw/cmd_fill_engine.sv
hw/cmd_pixel_write.sv
hw/panel_control_top.sv
testbench/panel_control_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= panel_control_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= Done: no errors

SOURCES := $(shell cat $(FILE_LIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)

//--- testbench/panel_control_tb.sv
/*
 * Testbench for the LED panel command controller. Sends random command streams
 * and checks settings and frame-buffer writes against a reference model.
 */
`timescale 1ns/1ps
`default_nettype none

module panel_control_tb;

    // bytes over all tests, plus the fills that hold the host back
    localparam int TOTAL_BYTES = 40 + 2 * 40 + 3 + 4 * 20 + 3;
    localparam int FILL_CMDS = 3;
    localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 200 + FILL_CMDS * panel_pkg::FB_DEPTH + 8;

    logic clk_in = 1'b0;
    logic reset;
    panel_pkg::byte_t data_rx;
    logic data_ready_n;
    panel_pkg::rgb_enable_t rgb_enable;
    panel_pkg::brightness_t brightness;
    panel_pkg::fb_write_t fb_write;
    logic busy;
    logic ready_for_data;

    panel_pkg::rgb_enable_t exp_rgb;
    panel_pkg::brightness_t exp_bright;
    panel_pkg::byte_t fb_obs [panel_pkg::FB_DEPTH];
    panel_pkg::byte_t fb_exp [panel_pkg::FB_DEPTH];
    panel_pkg::fb_write_t wr_log [$];
    logic [15:0] lfsr_state = 16'd12856;
    logic check_req = 1'b0;
    logic fill_watch = 1'b0;
    int error_count = 0;
    int check_count = 0;
    int test_num = 0;
    int errors_at_start = 0;
    string test_name;

    panel_pkg::byte_t colour_ops [6] = '{"R", "r", "G", "g", "B", "b"};
    // '7', 'x' and 'Q' are not opcodes
    panel_pkg::byte_t bright_ops [12] = '{"0", "1", "2", "3", "4", "5", "6", "9",
                                          "T", "7", "x", "Q"};

    panel_control_top i_dut (
        .clk_in(clk_in),
        .reset(reset),
        .data_rx(data_rx),
        .data_ready_n(data_ready_n),
        .rgb_enable(rgb_enable),
        .brightness(brightness),
        .fb_write(fb_write),
        .busy(busy),
        .ready_for_data(ready_for_data)
    );

    always #4 clk_in = ~clk_in;

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic panel_pkg::byte_t take_bits(input int nbits);
        panel_pkg::byte_t val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            val = {val[6:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic panel_pkg::rgb_enable_t ref_rgb(input panel_pkg::rgb_enable_t cur,
                                                       input panel_pkg::byte_t op);
        panel_pkg::rgb_enable_t nxt;
        nxt = cur;
        case (op)
            panel_pkg::RED_ENABLE: nxt.red = 1'b1;
            panel_pkg::RED_DISABLE: nxt.red = 1'b0;
            panel_pkg::GREEN_ENABLE: nxt.green = 1'b1;
            panel_pkg::GREEN_DISABLE: nxt.green = 1'b0;
            panel_pkg::BLUE_ENABLE: nxt.blue = 1'b1;
            panel_pkg::BLUE_DISABLE: nxt.blue = 1'b0;
            default: nxt = cur;
        endcase
        return nxt;
    endfunction

    function automatic panel_pkg::brightness_t ref_brightness(input panel_pkg::brightness_t cur,
                                                              input panel_pkg::byte_t op);
        panel_pkg::brightness_t nxt;
        int plane;
        nxt = cur;
        if (op == panel_pkg::BRIGHTNESS_ZERO) begin
            nxt = '0;
        end else if (op == panel_pkg::BRIGHTNESS_NINE) begin
            nxt = '1;
        end else if (op >= panel_pkg::BRIGHTNESS_ONE && op <= panel_pkg::BRIGHTNESS_SIX) begin
            // digit n names plane LEVELS-n, so '1' is the top plane
            plane = panel_pkg::BRIGHTNESS_LEVELS - int'(op - panel_pkg::BRIGHTNESS_ZERO);
            nxt[plane] = ~nxt[plane];
        end
        return nxt;
    endfunction

    // row-major position, coordinates wrap at the panel edges
    function automatic panel_pkg::fb_addr_t ref_addr(input panel_pkg::byte_t x,
                                                     input panel_pkg::byte_t y);
        int index;
        index = (int'(y) % panel_pkg::PANEL_HEIGHT) * panel_pkg::PANEL_WIDTH
                + int'(x) % panel_pkg::PANEL_WIDTH;
        return panel_pkg::fb_addr_t'(index);
    endfunction

    task automatic report_problem(input string msg);
        error_count++;
        $display("%0t ns: %s", $time, msg);
    endtask

    task automatic check_rgb(input panel_pkg::rgb_enable_t got, input panel_pkg::rgb_enable_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error %0t ns: rgb_enable is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_brightness(input panel_pkg::brightness_t got,
                                    input panel_pkg::brightness_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error %0t ns: brightness is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_write(input panel_pkg::fb_write_t got, input panel_pkg::fb_write_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error %0t ns: write we=%b addr=%0d data=%h, expected we=%b addr=%0d data=%h",
                     $time, got.we, got.addr, got.data, exp.we, exp.addr, exp.data);
        end
    endtask

    task automatic check_frame();
        for (int i = 0; i < panel_pkg::FB_DEPTH; i++) begin
            check_count++;
            if (fb_obs[i] !== fb_exp[i]) begin
                error_count++;
                $display("Error %0t ns: frame word %0d is %h, expected %h",
                         $time, i, fb_obs[i], fb_exp[i]);
            end
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic send_byte(input panel_pkg::byte_t value);
        @(negedge clk_in);
        while (!ready_for_data) begin
            @(negedge clk_in);
        end
        @(posedge clk_in);
        data_rx <= value;
        data_ready_n <= 1'b0;
        @(posedge clk_in);
        data_ready_n <= 1'b1;
    endtask

    // hands over to the compare process and waits for its checks
    task automatic compare_outputs();
        check_req = 1'b1;
        wait (!check_req);
    endtask

    task automatic verify_sweep(input panel_pkg::byte_t colour);
        panel_pkg::fb_write_t exp_wr;
        if (wr_log.size() != panel_pkg::FB_DEPTH) begin
            report_problem($sformatf("fill made %0d writes instead of %0d",
                                     wr_log.size(), panel_pkg::FB_DEPTH));
        end
        for (int i = 0; i < wr_log.size(); i++) begin
            exp_wr.we = 1'b1;
            exp_wr.addr = panel_pkg::fb_addr_t'(i);
            exp_wr.data = colour;
            check_write(wr_log[i], exp_wr);
        end
        for (int i = 0; i < panel_pkg::FB_DEPTH; i++) begin
            fb_exp[i] = colour;
        end
        check_frame();
    endtask

    task automatic start_test(input string name);
        test_num++;
        test_name = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        $display("test %0d %s: %s", test_num, test_name,
                 (error_count == errors_at_start) ? "ok" : "failed");
    endtask

    // writes are one cycle long, so each is seen once at the falling edge
    always @(negedge clk_in) begin
        if (!reset && fb_write.we) begin
            wr_log.push_back(fb_write);
            fb_obs[fb_write.addr] = fb_write.data;
            if (fill_watch && ready_for_data) begin
                report_problem("ready_for_data was high while the fill was writing");
            end
        end
    end

    initial begin : compare_proc
        forever begin
            wait (check_req);
            @(negedge clk_in);
            while (busy || !ready_for_data) begin
                @(negedge clk_in);
            end
            check_rgb(rgb_enable, exp_rgb);
            check_brightness(brightness, exp_bright);
            check_req = 1'b0;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("timeout: the controller stopped taking bytes or never went idle");
        $display("Done: errors found");
        $finish;
    end

    initial begin : stimulus
        panel_pkg::byte_t op;
        panel_pkg::byte_t x;
        panel_pkg::byte_t y;
        panel_pkg::byte_t colour;
        panel_pkg::fb_write_t exp_wr;
        reset = 1'b1;
        data_rx = '0;
        data_ready_n = 1'b1;
        for (int i = 0; i < panel_pkg::FB_DEPTH; i++) begin
            fb_obs[i] = '0;
            fb_exp[i] = '0;
        end
        repeat (8) @(posedge clk_in);
        reset <= 1'b0;

        start_test("reset state");
        @(negedge clk_in);
        exp_rgb = '1;
        exp_bright = '1;
        check_rgb(rgb_enable, exp_rgb);
        check_brightness(brightness, exp_bright);
        check_flag(busy, 1'b0, "busy");
        check_flag(ready_for_data, 1'b1, "ready_for_data");
        end_test();

        start_test("colour enables");
        for (int n = 0; n < 40; n++) begin
            op = colour_ops[take_bits(3) % 6];
            send_byte(op);
            exp_rgb = ref_rgb(exp_rgb, op);
            compare_outputs();
        end
        end_test();

        start_test("brightness planes");
        for (int n = 0; n < 40; n++) begin
            op = bright_ops[take_bits(4) % 12];
            send_byte(op);
            if (op == panel_pkg::READBRIGHTNESS) begin
                colour = take_bits(8);
                send_byte(colour);
                exp_bright = colour[panel_pkg::BRIGHTNESS_LEVELS-1:0];
            end else begin
                exp_bright = ref_brightness(exp_bright, op);
            end
            compare_outputs();
        end
        end_test();

        start_test("fill and blank");
        colour = take_bits(8);
        fill_watch = 1'b1;
        wr_log.delete();
        send_byte(panel_pkg::FILLPANEL);
        send_byte(colour);
        compare_outputs();
        verify_sweep(colour);
        wr_log.delete();
        send_byte(panel_pkg::BLANKPANEL);
        compare_outputs();
        verify_sweep('0);
        fill_watch = 1'b0;
        end_test();

        start_test("pixel writes");
        for (int n = 0; n < 20; n++) begin
            x = take_bits(8);
            y = take_bits(8);
            colour = take_bits(8);
            wr_log.delete();
            send_byte(panel_pkg::PIXELWRITE);
            send_byte(x);
            send_byte(y);
            send_byte(colour);
            compare_outputs();
            exp_wr.we = 1'b1;
            exp_wr.addr = ref_addr(x, y);
            exp_wr.data = colour;
            if (wr_log.size() != 1) begin
                report_problem($sformatf("pixel command made %0d writes", wr_log.size()));
            end else begin
                check_write(wr_log[0], exp_wr);
            end
            fb_exp[exp_wr.addr] = colour;
        end
        check_frame();
        end_test();

        start_test("byte held during fill");
        colour = take_bits(8);
        // flip green so the held byte always changes rgb_enable
        op = exp_rgb.green ? panel_pkg::GREEN_DISABLE : panel_pkg::GREEN_ENABLE;
        fill_watch = 1'b1;
        wr_log.delete();
        send_byte(panel_pkg::FILLPANEL);
        send_byte(colour);
        send_byte(op);
        if (wr_log.size() != panel_pkg::FB_DEPTH) begin
            report_problem("a byte was taken before the fill had finished");
        end
        exp_rgb = ref_rgb(exp_rgb, op);
        compare_outputs();
        fill_watch = 1'b0;
        verify_sweep(colour);
        end_test();

        $display("tests: %0d, checks: %0d, errors: %0d", test_num, check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/panel_control_top.sv
/*
 * Top level of the LED panel command controller.
 * Takes host bytes and drives colour enables, brightness planes and frame-buffer writes.
 */
`timescale 1ns/1ps
`default_nettype none

module panel_control_top (
    input wire clk_in,
    input wire reset,
    input wire panel_pkg::byte_t data_rx,
    input wire data_ready_n,
    output panel_pkg::rgb_enable_t rgb_enable,
    output panel_pkg::brightness_t brightness,
    output panel_pkg::fb_write_t fb_write,
    output logic busy,
    output logic ready_for_data
);

    panel_pkg::setting_req_t setting_req;
    panel_pkg::fill_req_t fill_req;
    panel_pkg::fb_write_t fill_write;
    panel_pkg::fb_write_t pixel_write;
    panel_pkg::byte_t pixel_byte;
    logic pixel_strobe;
    logic fill_done;
    logic pixel_done;

    opcode_dispatch i_dispatch (
        .clk_in(clk_in),
        .reset(reset),
        .data_rx(data_rx),
        .data_ready_n(data_ready_n),
        .fill_write(fill_write),
        .fill_done(fill_done),
        .pixel_write(pixel_write),
        .pixel_done(pixel_done),
        .setting_req(setting_req),
        .fill_req(fill_req),
        .pixel_byte(pixel_byte),
        .pixel_strobe(pixel_strobe),
        .fb_write(fb_write),
        .busy(busy),
        .ready_for_data(ready_for_data)
    );

    display_settings i_settings (
        .clk_in(clk_in),
        .reset(reset),
        .setting_req(setting_req),
        .rgb_enable(rgb_enable),
        .brightness(brightness)
    );

    // serves both blank (colour 0) and fill
    cmd_fill_engine i_fill (
        .clk_in(clk_in),
        .reset(reset),
        .fill_req(fill_req),
        .fill_write(fill_write),
        .fill_done(fill_done)
    );

    cmd_pixel_write i_pixel (
        .clk_in(clk_in),
        .reset(reset),
        .pixel_byte(pixel_byte),
        .pixel_strobe(pixel_strobe),
        .pixel_write(pixel_write),
        .pixel_done(pixel_done)
    );

endmodule

`default_nettype wire

//--- hw/cmd_pixel_write.sv
/*
 * Collects x, y and colour bytes for one pixel and issues a single frame-buffer write.
 * The write and the done pulse come one cycle after the colour byte.
 */
`timescale 1ns/1ps
`default_nettype none

module cmd_pixel_write (
    input wire clk_in,
    input wire reset,
    input wire panel_pkg::byte_t pixel_byte,
    input wire pixel_strobe,
    output panel_pkg::fb_write_t pixel_write,
    output logic pixel_done
);

    logic [1:0] arg_count;
    logic [panel_pkg::X_BITS-1:0] x_reg;
    logic [panel_pkg::Y_BITS-1:0] y_reg;
    logic write_we;
    panel_pkg::fb_addr_t write_addr;
    panel_pkg::byte_t write_data;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            arg_count <= 2'd0;
            write_we <= 1'b0;
        end else begin
            write_we <= 1'b0;
            if (pixel_strobe) begin
                if (arg_count == 2'd2) begin
                    write_we <= 1'b1;
                    arg_count <= 2'd0;
                end else begin
                    arg_count <= arg_count + 2'd1;
                end
            end
        end
    end

    // coordinates keep only their low bits
    always_ff @(posedge clk_in) begin
        if (pixel_strobe) begin
            case (arg_count)
                2'd0: x_reg <= pixel_byte[panel_pkg::X_BITS-1:0];
                2'd1: y_reg <= pixel_byte[panel_pkg::Y_BITS-1:0];
                default: begin
                    write_addr <= {y_reg, x_reg};
                    write_data <= pixel_byte;
                end
            endcase
        end
    end

    assign pixel_write.we = write_we;
    assign pixel_write.addr = write_addr;
    assign pixel_write.data = write_data;
    assign pixel_done = write_we;

    // each host byte must be counted once
    a_one_strobe_per_byte: assert property (@(posedge clk_in) disable iff (reset)
        pixel_strobe |=> !pixel_strobe)
        else $error("pixel byte strobed on consecutive cycles");

endmodule

`default_nettype wire

//--- hw/cmd_fill_engine.sv
/*
 * Sweeps every frame-buffer address once, ascending, with a single colour.
 * Used for both blank (colour 0) and fill panel.
 */
`timescale 1ns/1ps
`default_nettype none

module cmd_fill_engine (
    input wire clk_in,
    input wire reset,
    input wire panel_pkg::fill_req_t fill_req,
    output panel_pkg::fb_write_t fill_write,
    output logic fill_done
);

    logic active;
    panel_pkg::fb_addr_t addr;
    panel_pkg::byte_t color;
    logic last_addr;

    assign last_addr = (addr == panel_pkg::fb_addr_t'(panel_pkg::FB_DEPTH - 1));

    always_ff @(posedge clk_in) begin
        if (reset) begin
            active <= 1'b0;
            addr <= '0;
        end else if (fill_req.start) begin
            active <= 1'b1;
            addr <= '0;
        end else if (active) begin
            if (last_addr) begin
                active <= 1'b0;
            end
            addr <= addr + 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (fill_req.start) begin
            color <= fill_req.color;
        end
    end

    // one write per cycle while active
    assign fill_write.we = active;
    assign fill_write.addr = addr;
    assign fill_write.data = color;
    assign fill_done = active && last_addr;

    // a new sweep may only start once the previous one has ended
    a_no_restart: assert property (@(posedge clk_in) disable iff (reset)
        fill_req.start |-> !active)
        else $error("fill start during a sweep");

endmodule

`default_nettype wire

//--- hw/display_settings.sv
/*
 * Colour-enable and brightness-plane registers.
 * Applies setting opcodes and brightness arguments from the dispatcher.
 */
`timescale 1ns/1ps
`default_nettype none

module display_settings (
    input wire clk_in,
    input wire reset,
    input wire panel_pkg::setting_req_t setting_req,
    output panel_pkg::rgb_enable_t rgb_enable,
    output panel_pkg::brightness_t brightness
);

    localparam int TOP = panel_pkg::BRIGHTNESS_LEVELS - 1;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb_enable <= '1;
            brightness <= '1;
        end else if (setting_req.strobe) begin
            if (setting_req.load) begin
                brightness <= setting_req.value[panel_pkg::BRIGHTNESS_LEVELS-1:0];
            end else begin
                case (setting_req.value)
                    panel_pkg::RED_ENABLE: rgb_enable.red <= 1'b1;
                    panel_pkg::RED_DISABLE: rgb_enable.red <= 1'b0;
                    panel_pkg::GREEN_ENABLE: rgb_enable.green <= 1'b1;
                    panel_pkg::GREEN_DISABLE: rgb_enable.green <= 1'b0;
                    panel_pkg::BLUE_ENABLE: rgb_enable.blue <= 1'b1;
                    panel_pkg::BLUE_DISABLE: rgb_enable.blue <= 1'b0;
                    // '1' flips the most significant plane, '6' the least
                    panel_pkg::BRIGHTNESS_ONE: begin
                        brightness[TOP] <= ~brightness[TOP];
                    end
                    panel_pkg::BRIGHTNESS_TWO: begin
                        brightness[TOP-1] <= ~brightness[TOP-1];
                    end
                    panel_pkg::BRIGHTNESS_THREE: begin
                        brightness[TOP-2] <= ~brightness[TOP-2];
                    end
                    panel_pkg::BRIGHTNESS_FOUR: begin
                        brightness[TOP-3] <= ~brightness[TOP-3];
                    end
                    panel_pkg::BRIGHTNESS_FIVE: begin
                        brightness[TOP-4] <= ~brightness[TOP-4];
                    end
                    panel_pkg::BRIGHTNESS_SIX: begin
                        brightness[TOP-5] <= ~brightness[TOP-5];
                    end
                    panel_pkg::BRIGHTNESS_ZERO: brightness <= '0;
                    panel_pkg::BRIGHTNESS_NINE: brightness <= '1;
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/opcode_dispatch.sv
/*
 * Latches host bytes, runs the command FSM and hands work to the settings block
 * and the two frame-buffer engines. Also picks which engine drives the frame-buffer write.
 */
`timescale 1ns/1ps
`default_nettype none

module opcode_dispatch (
    input wire clk_in,
    input wire reset,
    input wire panel_pkg::byte_t data_rx,
    input wire data_ready_n,
    input wire panel_pkg::fb_write_t fill_write,
    input wire fill_done,
    input wire panel_pkg::fb_write_t pixel_write,
    input wire pixel_done,
    output panel_pkg::setting_req_t setting_req,
    output panel_pkg::fill_req_t fill_req,
    output panel_pkg::byte_t pixel_byte,
    output logic pixel_strobe,
    output panel_pkg::fb_write_t fb_write,
    output logic busy,
    output logic ready_for_data
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_BRIGHT_ARG,
        ST_FILL_COLOR,
        ST_FILL,
        ST_PIXEL
    } state_t;

    typedef enum logic [2:0] {
        CLS_NONE,
        CLS_SETTING,
        CLS_BRIGHT_ARG,
        CLS_BLANK,
        CLS_FILL,
        CLS_PIXEL
    } op_class_t;

    state_t state;
    panel_pkg::byte_t rx_byte;
    logic rx_valid;
    logic accept;
    op_class_t op_class;

    function automatic op_class_t classify(input panel_pkg::byte_t op);
        case (op)
            panel_pkg::RED_ENABLE, panel_pkg::RED_DISABLE,
            panel_pkg::GREEN_ENABLE, panel_pkg::GREEN_DISABLE,
            panel_pkg::BLUE_ENABLE, panel_pkg::BLUE_DISABLE,
            panel_pkg::BRIGHTNESS_ZERO, panel_pkg::BRIGHTNESS_ONE,
            panel_pkg::BRIGHTNESS_TWO, panel_pkg::BRIGHTNESS_THREE,
            panel_pkg::BRIGHTNESS_FOUR, panel_pkg::BRIGHTNESS_FIVE,
            panel_pkg::BRIGHTNESS_SIX, panel_pkg::BRIGHTNESS_NINE: return CLS_SETTING;
            panel_pkg::READBRIGHTNESS: return CLS_BRIGHT_ARG;
            panel_pkg::BLANKPANEL: return CLS_BLANK;
            panel_pkg::FILLPANEL: return CLS_FILL;
            panel_pkg::PIXELWRITE: return CLS_PIXEL;
            default: return CLS_NONE;
        endcase
    endfunction

    assign accept = !data_ready_n && ready_for_data;
    assign op_class = classify(rx_byte);

    // byte is valid for exactly one cycle after the edge that took it
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= accept;
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            rx_byte <= data_rx;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (rx_valid) begin
                        case (op_class)
                            CLS_BRIGHT_ARG: state <= ST_BRIGHT_ARG;
                            CLS_BLANK: state <= ST_FILL;
                            CLS_FILL: state <= ST_FILL_COLOR;
                            CLS_PIXEL: state <= ST_PIXEL;
                            default: state <= ST_IDLE;
                        endcase
                    end
                end
                ST_BRIGHT_ARG: if (rx_valid) state <= ST_IDLE;
                ST_FILL_COLOR: if (rx_valid) state <= ST_FILL;
                ST_FILL: if (fill_done) state <= ST_IDLE;
                ST_PIXEL: if (pixel_done) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_comb begin
        setting_req.value = rx_byte;
        setting_req.strobe = rx_valid && ((state == ST_BRIGHT_ARG) ||
                             (state == ST_IDLE && op_class == CLS_SETTING));
        setting_req.load = (state == ST_BRIGHT_ARG);
        // blank is a fill with colour 0
        fill_req.color = (state == ST_FILL_COLOR) ? rx_byte : '0;
        fill_req.start = rx_valid && ((state == ST_FILL_COLOR) ||
                         (state == ST_IDLE && op_class == CLS_BLANK));
    end

    assign pixel_byte = rx_byte;
    assign pixel_strobe = rx_valid && (state == ST_PIXEL);

    always_comb begin
        case (state)
            ST_FILL: fb_write = fill_write;
            ST_PIXEL: fb_write = pixel_write;
            default: fb_write = '0;
        endcase
    end

    assign busy = (state != ST_IDLE) || rx_valid;
    assign ready_for_data = (state != ST_FILL) && !rx_valid;

    // host must respect back-pressure
    a_host_backpressure: assert property (@(posedge clk_in) disable iff (reset)
        !data_ready_n |-> ready_for_data)
        else $error("host strobe while not ready");

    a_fill_done_in_fill: assert property (@(posedge clk_in) disable iff (reset)
        fill_done |-> state == ST_FILL)
        else $error("fill done outside fill state");

endmodule

`default_nettype wire

//--- hw/panel_pkg.sv
/*
 * Shared sizes, opcodes and bus types for the LED panel command controller.
 * Every RTL block refers to these by scoped name.
 */
`default_nettype none

package panel_pkg;

    // panel geometry
    localparam int PANEL_WIDTH = 16;
    localparam int PANEL_HEIGHT = 8;
    localparam int X_BITS = 4;
    localparam int Y_BITS = 3;
    localparam int FB_DEPTH = PANEL_WIDTH * PANEL_HEIGHT;
    localparam int BRIGHTNESS_LEVELS = 6;

    typedef logic [7:0] byte_t;
    // y in the high bits, x in the low bits
    typedef logic [X_BITS+Y_BITS-1:0] fb_addr_t;
    typedef logic [BRIGHTNESS_LEVELS-1:0] brightness_t;

    // host opcodes, plain ASCII
    localparam byte_t RED_ENABLE = "R";
    localparam byte_t RED_DISABLE = "r";
    localparam byte_t GREEN_ENABLE = "G";
    localparam byte_t GREEN_DISABLE = "g";
    localparam byte_t BLUE_ENABLE = "B";
    localparam byte_t BLUE_DISABLE = "b";
    localparam byte_t BRIGHTNESS_ZERO = "0";
    localparam byte_t BRIGHTNESS_ONE = "1";
    localparam byte_t BRIGHTNESS_TWO = "2";
    localparam byte_t BRIGHTNESS_THREE = "3";
    localparam byte_t BRIGHTNESS_FOUR = "4";
    localparam byte_t BRIGHTNESS_FIVE = "5";
    localparam byte_t BRIGHTNESS_SIX = "6";
    localparam byte_t BRIGHTNESS_NINE = "9";
    localparam byte_t READBRIGHTNESS = "T";
    localparam byte_t BLANKPANEL = "c";
    localparam byte_t FILLPANEL = "F";
    localparam byte_t PIXELWRITE = "P";

    typedef struct packed {
        logic we;
        fb_addr_t addr;
        byte_t data;
    } fb_write_t;

    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } rgb_enable_t;

    // load set: value is a brightness argument, otherwise an opcode
    typedef struct packed {
        logic strobe;
        logic load;
        byte_t value;
    } setting_req_t;

    typedef struct packed {
        logic start;
        byte_t color;
    } fill_req_t;

endpackage

`default_nettype wire
